//--- Bender.yml
package:
  name: fetch_stage

sources:
  - source/fetch_pkg.sv
  - source/progCounter.sv
  - source/instrMemory.sv
  - source/controlDecode.sv
  - source/hazardDetect.sv
  - source/fetchStage.sv
  - target: test
    files:
      - test/fetchStage_properties.sv
      - test/fetchChecker.sv
      - test/fetchStage_tb.sv

//--- files.f
source/fetch_pkg.sv
source/progCounter.sv
source/instrMemory.sv
source/controlDecode.sv
source/hazardDetect.sv
source/fetchStage.sv
test/fetchStage_properties.sv
test/fetchChecker.sv
test/fetchStage_tb.sv

//--- source/controlDecode.sv
// Opcode decoder for control strobes, register-use flags and destination select
`timescale 1ns/1ps
`default_nettype none

module controlDecode import fetch_pkg::*; (
    input  wire instrWord_t instr,
    output logic            regWrite,
    output destSel_t        destSel,
    output logic            memEnable,
    output logic            memWr,
    output logic            val2Reg,
    output logic            aluSel,
    output logic      [2:0] immSel,
    output logic            linkReg,
    output logic            bFlag,
    output logic            jFlag,
    output logic            regJmp,
    output logic            halt,
    output logic            ctrlErr,
    output logic            isLoad,
    output logic            readsRs,
    output logic            readsRt
);

    always_comb begin
        regWrite  = 1'b0;
        destSel   = DEST_RD_R;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        immSel    = IMM_NONE;
        linkReg   = 1'b0;
        bFlag     = 1'b0;
        jFlag     = 1'b0;
        regJmp    = 1'b0;
        halt      = 1'b0;
        ctrlErr   = 1'b0;
        isLoad    = 1'b0;
        readsRs   = 1'b1;   // Most opcodes use rs
        readsRt   = 1'b0;

        case (instr.r.opcode)
            OP_HALT: begin
                halt    = 1'b1;
                readsRs = 1'b0;
            end
            OP_NOP:  readsRs = 1'b0;
            OP_ALU: begin
                regWrite = 1'b1;
                readsRt  = 1'b1;
            end
            OP_ADDI, OP_SUBI: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_I;
                aluSel   = 1'b1;     // Immediate operand
                immSel   = IMM_5;
            end
            OP_LD: begin
                regWrite  = 1'b1;
                destSel   = DEST_RD_I;
                memEnable = 1'b1;
                val2Reg   = 1'b1;    // Write back memory data
                aluSel    = 1'b1;
                immSel    = IMM_5;
                isLoad    = 1'b1;
            end
            OP_ST: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;
                immSel    = IMM_5;
                readsRt   = 1'b1;    // Store data register
            end
            OP_LBI: begin
                regWrite = 1'b1;
                destSel  = DEST_RS;
                immSel   = IMM_8;
                readsRs  = 1'b0;
            end
            OP_BEQZ, OP_BNEZ: begin
                bFlag  = 1'b1;
                immSel = IMM_8;
            end
            OP_J: begin
                jFlag   = 1'b1;
                immSel  = IMM_11;
                readsRs = 1'b0;
            end
            OP_JR: begin
                jFlag  = 1'b1;
                regJmp = 1'b1;
                immSel = IMM_8;
            end
            OP_JAL: begin
                regWrite = 1'b1;
                destSel  = DEST_R7;
                linkReg  = 1'b1;
                jFlag    = 1'b1;
                immSel   = IMM_11;
                readsRs  = 1'b0;
            end
            default: ctrlErr = 1'b1;  // Illegal opcode, strobes stay low
        endcase
    end

endmodule

`default_nettype wire

//--- source/fetchStage.sv
// Fetch stage top with PC, instruction memory, hazard unit, two decoders and NOP mux
`timescale 1ns/1ps
`default_nettype none

module fetchStage import fetch_pkg::*; #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire logic                     pcSel,
    input  wire logic [15:0]              branchTarget,
    input  wire logic                     loadEn,
    input  wire logic [MEM_ADDR_BITS-1:0] loadAddr,
    input  wire logic [15:0]              loadData,
    output logic      [15:0]              pc,
    output logic      [15:0]              instr,
    output logic                          valid,
    output logic                          regWrite,
    output logic      [2:0]               writeRegAddr,
    output logic                          memEnable,
    output logic                          memWr,
    output logic                          val2Reg,
    output logic                          aluSel,
    output logic      [2:0]               immSel,
    output logic                          linkReg,
    output logic                          bFlag,
    output logic                          jFlag,
    output logic                          regJmp,
    output logic                          halt,
    output logic                          ctrlErr
);

    logic [15:0] rawInstr;
    instrWord_t  rawWord;
    instrWord_t  issuedWord;
    destSel_t    destSel;
    logic        nop;
    logic        stall;
    logic        decRegWrite, decMemEnable, decMemWr, decHalt, decCtrlErr;
    logic        isLoad;
    logic        chkReadsRs, chkReadsRt;

    progCounter u_pc (
        .clk(clk), .rstN(rstN), .pcSel(pcSel), .branchTarget(branchTarget),
        .stall(stall), .halt(decHalt), .pc(pc)
    );

    instrMemory #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_imem (
        .clk(clk), .addr(pc), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .rdata(rawInstr)
    );

    assign rawWord    = rawInstr;
    assign issuedWord = nop ? NOP_WORD : rawInstr;   // Bubble on load-use
    assign instr      = issuedWord;

    hazardDetect u_hazard (
        .clk(clk), .rstN(rstN), .instr(rawWord), .readsRs(chkReadsRs),
        .readsRt(chkReadsRt), .issuedIsLoad(isLoad), .issuedDest(writeRegAddr),
        .nop(nop), .stall(stall)
    );

    controlDecode issueDecode (
        .instr(issuedWord), .regWrite(decRegWrite), .destSel(destSel),
        .memEnable(decMemEnable), .memWr(decMemWr), .val2Reg(val2Reg),
        .aluSel(aluSel), .immSel(immSel), .linkReg(linkReg), .bFlag(bFlag),
        .jFlag(jFlag), .regJmp(regJmp), .halt(decHalt), .ctrlErr(decCtrlErr),
        .isLoad(isLoad), .readsRs(), .readsRt()
    );

    // Raw word decoded again, only its register reads matter
    controlDecode checkDecode (
        .instr(rawWord), .regWrite(), .destSel(), .memEnable(), .memWr(),
        .val2Reg(), .aluSel(), .immSel(), .linkReg(), .bFlag(), .jFlag(),
        .regJmp(), .halt(), .ctrlErr(), .isLoad(),
        .readsRs(chkReadsRs), .readsRt(chkReadsRt)
    );

    always_comb begin
        case (destSel)
            DEST_RS:   writeRegAddr = issuedWord.r.rs;
            DEST_RD_R: writeRegAddr = issuedWord.r.rd;
            DEST_R7:   writeRegAddr = 3'd7;
            DEST_RD_I: writeRegAddr = issuedWord.i.rd;
            default:   writeRegAddr = issuedWord.r.rd;
        endcase
    end

    // Strobes forced low while reset is held
    assign valid     = rstN && !nop;
    assign regWrite  = rstN && decRegWrite;
    assign memEnable = rstN && decMemEnable;
    assign memWr     = rstN && decMemWr;
    assign halt      = rstN && decHalt;
    assign ctrlErr   = rstN && decCtrlErr;

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
// Opcodes, instruction word formats, NOP word, destination and immediate select codes
`default_nettype none

package fetch_pkg;

    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_NOP  = 5'b00001,
        OP_J    = 5'b00100,
        OP_JR   = 5'b00101,
        OP_JAL  = 5'b00110,
        OP_ADDI = 5'b01000,
        OP_SUBI = 5'b01001,
        OP_BEQZ = 5'b01100,
        OP_BNEZ = 5'b01101,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_LBI  = 5'b11000,
        OP_ALU  = 5'b11011
    } opcode_t;

    // Register-register layout
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] funct;
    } rFormat_t;

    // Immediate layout, rd sits where rt is in R-format
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } iFormat_t;

    typedef union packed {
        rFormat_t r;
        iFormat_t i;
    } instrWord_t;

    // Which field names the register written back
    typedef enum logic [1:0] {
        DEST_RS   = 2'b00,
        DEST_RD_R = 2'b01,
        DEST_R7   = 2'b10,
        DEST_RD_I = 2'b11
    } destSel_t;

    // Immediate width select for the execute stage
    localparam logic [2:0] IMM_NONE = 3'd0;
    localparam logic [2:0] IMM_5    = 3'd1; // ADDI, SUBI, LD, ST
    localparam logic [2:0] IMM_8    = 3'd2; // LBI, branches, JR
    localparam logic [2:0] IMM_11   = 3'd3; // J, JAL displacement

    localparam logic [15:0] NOP_WORD = 16'h0800;

endpackage

`default_nettype wire

//--- source/hazardDetect.sv
// Load-use hazard detector with last issued load record
`timescale 1ns/1ps
`default_nettype none

module hazardDetect import fetch_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire instrWord_t instr,
    input  wire logic       readsRs,
    input  wire logic       readsRt,
    input  wire logic       issuedIsLoad,
    input  wire logic [2:0] issuedDest,
    output logic            nop,
    output logic            stall
);

    logic       loadValid;
    logic [2:0] loadDest;
    logic       rsHit;
    logic       rtHit;
    logic       useHit;

    // Flag follows the issued word every edge, so a stall never repeats
    always_ff @(posedge clk) begin
        if (!rstN) begin
            loadValid <= 1'b0;
        end else begin
            loadValid <= issuedIsLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (issuedIsLoad) begin
            loadDest <= issuedDest;
        end
    end

    // rt sits in the same bits for both formats
    assign rsHit  = readsRs && (instr.r.rs == loadDest);
    assign rtHit  = readsRt && (instr.r.rt == loadDest);
    assign useHit = loadValid && (rsHit || rtHit);

    assign nop   = useHit;   // Bubble into the issue slot
    assign stall = useHit;   // Hold the PC on the dependent word

endmodule

`default_nettype wire

//--- source/instrMemory.sv
// Word-addressed instruction memory, combinational read and synchronous load port
`timescale 1ns/1ps
`default_nettype none

module instrMemory #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  wire logic                     clk,
    input  wire logic [15:0]              addr,
    input  wire logic                     loadEn,
    input  wire logic [MEM_ADDR_BITS-1:0] loadAddr,
    input  wire logic [15:0]              loadData,
    output logic      [15:0]              rdata
);

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    logic [15:0]              mem [DEPTH];
    logic [MEM_ADDR_BITS-1:0] wordIdx;

    // Byte address to word index, upper bits drop so reads wrap
    assign wordIdx = addr[MEM_ADDR_BITS:1];

    assign rdata = mem[wordIdx];

    // Program load from the testbench side
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

endmodule

`default_nettype wire

//--- source/progCounter.sv
// Byte-addressed program counter with redirect, stall and halt hold
`timescale 1ns/1ps
`default_nettype none

module progCounter (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        pcSel,
    input  wire logic [15:0] branchTarget,
    input  wire logic        stall,
    input  wire logic        halt,
    output logic      [15:0] pc
);

    logic [15:0] pcNext;

    // Redirect wins over both hold conditions
    always_comb begin
        if (pcSel) begin
            pcNext = branchTarget;
        end else if (stall || halt) begin
            pcNext = pc;                // Re-fetch same word
        end else begin
            pcNext = pc + 16'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= 16'h0000;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

//--- test/fetchChecker.sv
// Reference model of the fetch stage with per-cycle output comparison and summary
`timescale 1ns/1ps
`default_nettype none

module fetchChecker import fetch_pkg::*; #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire logic                     pcSel,
    input  wire logic [15:0]              branchTarget,
    input  wire logic                     loadEn,
    input  wire logic [MEM_ADDR_BITS-1:0] loadAddr,
    input  wire logic [15:0]              loadData,
    input  wire logic [15:0]              pc,
    input  wire logic [15:0]              instr,
    input  wire logic                     valid, regWrite, memEnable, memWr, val2Reg, aluSel,
    input  wire logic [2:0]               writeRegAddr,
    input  wire logic [2:0]               immSel,
    input  wire logic                     linkReg, bFlag, jFlag, regJmp, halt, ctrlErr
);

    localparam logic [15:0] BUBBLE = 16'h0800;

    logic [15:0]              mem [2 ** MEM_ADDR_BITS];
    logic [15:0]              pcModel, pcNext;
    logic                     loadSeen, loadSeenNext;
    logic [2:0]               loadReg, loadRegNext;
    logic                     memWrite;
    logic [MEM_ADDR_BITS-1:0] memWriteAddr;
    logic [15:0]              memWriteData;
    int                       lastStep, stepNext;   // Behavior that moved the PC last
    int                       checks [1:6];
    int                       fails [1:6];
    int                       errorCount;

    initial begin
        pcModel      = '0;
        pcNext       = '0;
        loadSeenNext = 1'b0;
        loadRegNext  = '0;
        stepNext     = 1;
        memWrite     = 1'b0;
        errorCount   = 0;
        for (int b = 1; b <= 6; b++) begin
            checks[b] = 0;
            fails[b]  = 0;
        end
    end

    // Bits: regWrite memEnable memWr val2Reg aluSel immSel(3) linkReg bFlag jFlag regJmp
    //       halt ctrlErr destSel(2) readsRs readsRt
    function automatic logic [17:0] controlRow(input logic [4:0] op);
        case (op)
            OP_HALT:          return 18'b0_0_0_0_0_000_0_0_0_0_1_0_00_0_0;
            OP_NOP:           return 18'b0_0_0_0_0_000_0_0_0_0_0_0_00_0_0;
            OP_ALU:           return 18'b1_0_0_0_0_000_0_0_0_0_0_0_01_1_1;
            OP_ADDI, OP_SUBI: return 18'b1_0_0_0_1_001_0_0_0_0_0_0_11_1_0;
            OP_LD:            return 18'b1_1_0_1_1_001_0_0_0_0_0_0_11_1_0;
            OP_ST:            return 18'b0_1_1_0_1_001_0_0_0_0_0_0_00_1_1;
            OP_LBI:           return 18'b1_0_0_0_0_010_0_0_0_0_0_0_00_0_0;
            OP_BEQZ, OP_BNEZ: return 18'b0_0_0_0_0_010_0_1_0_0_0_0_00_1_0;
            OP_J:             return 18'b0_0_0_0_0_011_0_0_1_0_0_0_00_0_0;
            OP_JR:            return 18'b0_0_0_0_0_010_0_0_1_1_0_0_00_1_0;
            OP_JAL:           return 18'b1_0_0_0_0_011_1_0_1_0_0_0_10_0_0;
            default:          return 18'b0_0_0_0_0_000_0_0_0_0_0_1_00_1_0;
        endcase
    endfunction

    task automatic checkValue(input int tag, input string name,
                              input logic [15:0] expected, input logic [15:0] seen);
        checks[tag]++;
        if (seen !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, seen %h", $time, name,
                     expected, seen);
            fails[tag]++;
            errorCount++;
        end
    endtask

    // Compare mid-cycle, commit the model state on the rising edge
    always @(negedge clk) begin
        logic [15:0] raw;
        logic [15:0] issued;
        logic [17:0] rawRow;
        logic [17:0] row;
        logic        hit;
        logic [2:0]  dest;
        int          tag;
        raw    = mem[pcModel[MEM_ADDR_BITS:1]];
        rawRow = controlRow(raw[15:11]);
        hit    = loadSeen && ((rawRow[1] && raw[10:8] == loadReg) ||
                              (rawRow[0] && raw[7:5] == loadReg));
        issued = hit ? BUBBLE : raw;
        row    = controlRow(issued[15:11]);
        case (row[3:2])
            2'b00:   dest = issued[10:8];
            2'b01:   dest = issued[4:2];
            2'b10:   dest = 3'd7;
            default: dest = issued[7:5];
        endcase
        if (!rstN) begin
            checkValue(6, "valid", 0, valid);
            checkValue(6, "regWrite", 0, regWrite);
            checkValue(6, "memEnable", 0, memEnable);
            checkValue(6, "memWr", 0, memWr);
            checkValue(6, "halt", 0, halt);
            checkValue(6, "ctrlErr", 0, ctrlErr);
            pcNext       = '0;
            loadSeenNext = 1'b0;
            stepNext     = 1;
        end else begin
            tag = row[4] ? 6 : (row[5] ? 5 : 2);
            checkValue(lastStep, "pc", pcModel, pc);
            checkValue(hit ? 3 : 1, "instr", issued, instr);
            checkValue(hit ? 3 : 1, "valid", !hit, valid);
            checkValue(tag, "regWrite", row[17], regWrite);
            if (row[17]) checkValue(tag, "writeRegAddr", dest, writeRegAddr);
            checkValue(tag, "memEnable", row[16], memEnable);
            checkValue(tag, "memWr", row[15], memWr);
            checkValue(tag, "val2Reg", row[14], val2Reg);
            checkValue(tag, "aluSel", row[13], aluSel);
            checkValue(tag, "immSel", row[12:10], immSel);
            checkValue(tag, "linkReg", row[9], linkReg);
            checkValue(tag, "bFlag", row[8], bFlag);
            checkValue(tag, "jFlag", row[7], jFlag);
            checkValue(tag, "regJmp", row[6], regJmp);
            checkValue(tag, "halt", row[5], halt);
            checkValue(tag, "ctrlErr", row[4], ctrlErr);
            if (pcSel) begin
                pcNext   = branchTarget;
                stepNext = 4;
            end else if (hit) begin
                pcNext   = pcModel;          // Re-fetch the dependent word
                stepNext = 3;
            end else if (row[5]) begin
                pcNext   = pcModel;
                stepNext = 5;
            end else begin
                pcNext   = pcModel + 16'd2;
                stepNext = 1;
            end
            loadSeenNext = (issued[15:11] == OP_LD);
        end
        loadRegNext  = dest;
        memWrite     = loadEn;
        memWriteAddr = loadAddr;
        memWriteData = loadData;
    end

    always @(posedge clk) begin
        pcModel  <= pcNext;
        loadSeen <= loadSeenNext;
        loadReg  <= loadRegNext;
        lastStep <= stepNext;
        if (memWrite) mem[memWriteAddr] <= memWriteData;
    end

    task automatic printSummary(input int assertFails, output int failTotal);
        string names [1:6];
        int    totalChecks;
        names = '{"sequential fetch", "decode", "load-use hazard", "redirect", "halt",
                  "illegal and reset"};
        totalChecks = 0;
        for (int b = 1; b <= 6; b++) begin
            if (checks[b] == 0) begin
                $display("%s: never exercised in this run", names[b]);
                errorCount++;
            end else begin
                $display("%-18s %0d checks, %0d failures", names[b], checks[b], fails[b]);
            end
            totalChecks += checks[b];
        end
        $display("Totals: %0d checks, %0d failures, %0d assertion failures",
                 totalChecks, errorCount, assertFails);
        failTotal = errorCount;
    endtask

endmodule

`default_nettype wire

//--- test/fetchStage_properties.sv
// Bound assertions on stall length, NOP issue and halt hold of the fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchStage_properties import fetch_pkg::*; (
    input wire logic        clk,
    input wire logic        rstN,
    input wire logic        pcSel,
    input wire logic        stall,
    input wire logic        nop,
    input wire logic        halt,
    input wire logic [15:0] instr,
    input wire logic [15:0] pc
);

    int failCount = 0;

    stallOneCycle: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
        else begin
            $error("stall was high on two consecutive cycles");
            failCount++;
        end

    // Bubble issues and the PC waits for the re-fetch unless redirected
    nopIssuesBubble: assert property (@(posedge clk) disable iff (!rstN)
                                      nop |-> instr == NOP_WORD
                                      ##1 ($past(pcSel) || $stable(pc)))
        else begin
            $error("nop cycle did not issue the NOP word and hold the pc");
            failCount++;
        end

    // Halted word stays put until a redirect arrives
    haltHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
                                  halt && !pcSel |=> $stable(pc))
        else begin
            $error("pc moved while halted without a redirect");
            failCount++;
        end

endmodule

bind fetchStage fetchStage_properties u_props (
    .clk(clk), .rstN(rstN), .pcSel(pcSel), .stall(stall), .nop(nop),
    .halt(halt), .instr(instr), .pc(pc)
);

`default_nettype wire

//--- test/fetchStage_tb.sv
// Testbench top with clock, reset, program loading, random redirects and the DUT instance
`timescale 1ns/1ps
`default_nettype none

module fetchStage_tb import fetch_pkg::*; ();

    localparam int MEM_BITS   = 3;              // 8 words, loaded within one reset
    localparam int PROG_WORDS = 2 ** MEM_BITS;

    logic                clk = 1'b0;
    logic                rstN;
    logic                pcSel;
    logic [15:0]         branchTarget;
    logic                loadEn;
    logic [MEM_BITS-1:0] loadAddr;
    logic [15:0]         loadData;
    logic [15:0]         pc, instr;
    logic                valid, regWrite, memEnable, memWr, val2Reg, aluSel;
    logic [2:0]          writeRegAddr, immSel;
    logic                linkReg, bFlag, jFlag, regJmp, halt, ctrlErr;
    int                  errorCount;
    bit                  timedOut;
    logic [15:0]         progWords [PROG_WORDS];

    opcode_t legalOps [13] = '{OP_HALT, OP_NOP, OP_ST, OP_LD, OP_ADDI, OP_SUBI, OP_BEQZ,
                               OP_BNEZ, OP_J, OP_JR, OP_JAL, OP_LBI, OP_ALU};

    fetchStage #(.MEM_ADDR_BITS(MEM_BITS)) i_dut (
        .clk(clk), .rstN(rstN), .pcSel(pcSel), .branchTarget(branchTarget),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .pc(pc), .instr(instr), .valid(valid), .regWrite(regWrite),
        .writeRegAddr(writeRegAddr), .memEnable(memEnable), .memWr(memWr),
        .val2Reg(val2Reg), .aluSel(aluSel), .immSel(immSel), .linkReg(linkReg),
        .bFlag(bFlag), .jFlag(jFlag), .regJmp(regJmp), .halt(halt), .ctrlErr(ctrlErr)
    );

    fetchChecker #(.MEM_ADDR_BITS(MEM_BITS)) u_checker (.*);

    always #5 clk = ~clk;

    function automatic bit isLegal(input logic [4:0] op);
        foreach (legalOps[k]) begin
            if (legalOps[k] == op) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic bit readsSource(input logic [4:0] op);
        return op inside {OP_ALU, OP_ADDI, OP_SUBI, OP_LD, OP_ST, OP_BEQZ, OP_BNEZ, OP_JR};
    endfunction

    function automatic logic [15:0] randomTarget();
        logic [15:0] target;
        target    = 16'($urandom);
        target[0] = 1'b0;                        // Byte address of a word
        return target;
    endfunction

    task automatic buildProgram();
        logic [4:0] op;
        bit         sawIllegal;
        int         haltSlot;
        sawIllegal = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            if ($urandom_range(0, 9) == 0) begin
                op = 5'($urandom);
                while (isLegal(op)) op = 5'($urandom);
                sawIllegal = 1'b1;
            end else begin
                op = legalOps[$urandom_range(0, 12)];
            end
            progWords[i] = {op, 11'($urandom)};
        end
        // Load in front of a word that reads its destination
        for (int i = 1; i < PROG_WORDS; i++) begin
            if (readsSource(progWords[i][15:11]) && $urandom_range(0, 3) == 0) begin
                progWords[i-1] = {OP_LD, 3'($urandom), progWords[i][10:8], 5'($urandom)};
            end
        end
        haltSlot = $urandom_range(0, PROG_WORDS - 1);
        progWords[haltSlot][15:11] = OP_HALT;
        if (!sawIllegal) progWords[(haltSlot + 1) % PROG_WORDS][15:11] = 5'b11111;
    endtask

    // Reset stays low for 8 rising edges while the words are written
    task automatic loadProgram();
        buildProgram();
        @(posedge clk);
        rstN     <= 1'b0;
        pcSel    <= 1'b0;
        loadEn   <= 1'b1;
        loadAddr <= '0;
        loadData <= progWords[0];
        for (int i = 1; i < PROG_WORDS; i++) begin
            @(posedge clk);
            loadAddr <= MEM_BITS'(i);
            loadData <= progWords[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        rstN   <= 1'b1;
    endtask

    task automatic runRandom(input int cycles);
        logic haltSeen;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            haltSeen = halt;
            @(posedge clk);
            if (haltSeen || $urandom_range(0, 15) == 0) begin
                pcSel        <= 1'b1;
                branchTarget <= randomTarget();
            end else begin
                pcSel <= 1'b0;
            end
        end
    endtask

    // End on an issued word, leaving any halt by a redirect
    task automatic drainHalt();
        int   waitCount;
        logic issued;
        logic haltSeen;
        waitCount = 0;
        issued    = 1'b0;
        while (!issued && waitCount < 20) begin
            @(negedge clk);
            issued   = valid && !halt;
            haltSeen = halt;
            @(posedge clk);
            pcSel        <= haltSeen;
            branchTarget <= randomTarget();
            waitCount++;
        end
        if (!issued) begin
            $display("Timeout: no word was issued within 20 cycles at the end of the run");
            timedOut = 1'b1;
        end
    endtask

    initial begin
        rstN         = 1'b0;
        pcSel        = 1'b0;
        branchTarget = '0;
        loadEn       = 1'b0;
        loadAddr     = '0;
        loadData     = '0;
        timedOut     = 1'b0;
        errorCount   = 0;
        void'($urandom(32'hbead_8261));
        for (int prog = 0; prog < 4; prog++) begin
            loadProgram();
            runRandom(500);                      // 2000 cycles over four programs
        end
        drainHalt();
        u_checker.printSummary(i_dut.u_props.failCount, errorCount);
        if (timedOut || errorCount != 0 || i_dut.u_props.failCount != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire
